//--- hw/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// request opcodes, first byte with cmd_w high
`define NOC_OP_READ     8'h23
`define NOC_OP_WRITE    8'h63

// closes every read response, sent with cmd_r high
`define NOC_END_CODE    8'hE0

// response queue entries
`define NOC_FIFO_DEPTH  4

// a read covers at most three words
`define NOC_MAX_WORDS   3

// byte step between words of one read
`define NOC_WORD_STRIDE 32'd4

`endif

//--- hw/noc_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

    // response kinds, values double as the header byte on the response port
    typedef enum logic [7:0] {
        RESP_READ  = 8'h40,
        RESP_WRITE = 8'h80
    } resp_kind_e;

    // one finished command, as queued between parser and serializer
    // word 0 sits first, i.e. in the top bits
    typedef struct packed {
        resp_kind_e                          kind;   // header byte
        logic [7:0]                          src_id; // echoed back to requester
        logic [7:0]                          len;    // read length in bytes
        logic [0:`NOC_MAX_WORDS-1][31:0]     words;  // read data, unused for writes
    } resp_entry_t;

endpackage

`default_nettype wire

//--- hw/noc_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_cmd_parser
    import noc_pkg::*;
(
    input  wire logic        c,
    input  wire logic        rst,
    input  wire logic        cmd_w,
    input  wire logic [7:0]  data_w,
    input  wire logic [31:0] data_rd,
    input  wire logic        full,
    output logic             sel,
    output logic             rw,
    output logic [31:0]      addr,
    output logic [31:0]      data_wr,
    output logic             push,
    output resp_entry_t      entry
);

    // wide enough to count up to NOC_MAX_WORDS
    localparam int CW = $clog2(`NOC_MAX_WORDS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SRC,
        S_ADDR,
        S_LEN,
        S_WDATA,
        S_READ,
        S_PUSH
    } state_e;

    state_e       state;
    logic [1:0]   bcnt;      // byte position inside addr / data
    logic [31:0]  addr_sh;   // address bytes, lsb first
    logic [31:0]  data_sh;   // write data bytes, lsb first
    logic         rd_pend;   // a read strobe went out last cycle
    logic [CW-1:0] nwords;   // words in the current read
    logic [CW-1:0] iss_idx;  // word index on the bus right now
    logic [CW-1:0] cap_idx;  // next word slot to fill
    resp_entry_t  entry_q;

    logic         op_ok;

    // only the two known opcodes start a command
    assign op_ok = cmd_w && (data_w == `NOC_OP_READ || data_w == `NOC_OP_WRITE);

    // control path and bus strobes
    always_ff @(posedge c or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            sel     <= 1'b0;
            rw      <= 1'b0;
            addr    <= '0;
            data_wr <= '0;
            rd_pend <= 1'b0;
            bcnt    <= '0;
            nwords  <= '0;
            iss_idx <= '0;
            cap_idx <= '0;
        end else begin
            sel     <= 1'b0;         // strobes are single cycle unless re-armed
            rw      <= 1'b0;
            rd_pend <= sel && !rw;   // slave answers one cycle after a read strobe
            case (state)
                S_IDLE: begin
                    if (op_ok) begin
                        state <= S_SRC;
                    end
                end
                S_SRC: begin
                    bcnt  <= '0;
                    state <= S_ADDR;
                end
                S_ADDR: begin
                    bcnt <= bcnt + 2'd1;
                    if (bcnt == 2'd3) begin
                        state <= S_LEN;
                    end
                end
                S_LEN: begin
                    if (entry_q.kind == RESP_WRITE) begin
                        // length byte of a write is just skipped
                        bcnt  <= '0;
                        state <= S_WDATA;
                    end else begin
                        // first word read goes out on the next cycle
                        sel     <= 1'b1;
                        addr    <= addr_sh;
                        nwords  <= (data_w[3:2] == 2'd0) ? CW'(1) : CW'(data_w[3:2]);
                        iss_idx <= '0;
                        cap_idx <= '0;
                        state   <= S_READ;
                    end
                end
                S_WDATA: begin
                    bcnt <= bcnt + 2'd1;
                    if (bcnt == 2'd3) begin
                        sel     <= 1'b1;
                        rw      <= 1'b1;
                        addr    <= addr_sh;
                        data_wr <= {data_w, data_sh[31:8]};
                        state   <= S_PUSH;   // push lands with the strobe
                    end
                end
                S_READ: begin
                    // back to back reads, stride apart
                    if (sel && (iss_idx + CW'(1) < nwords)) begin
                        sel     <= 1'b1;
                        addr    <= addr + `NOC_WORD_STRIDE;
                        iss_idx <= iss_idx + CW'(1);
                    end
                    if (rd_pend) begin
                        cap_idx <= cap_idx + CW'(1);
                        if (cap_idx == nwords - CW'(1)) begin
                            state <= S_PUSH;    // last word in hand
                        end
                    end
                end
                S_PUSH: begin
                    // hold here while the queue has no room
                    if (!full) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // payload capture
    always_ff @(posedge c) begin
        if (state == S_IDLE && op_ok) begin
            entry_q.kind <= (data_w == `NOC_OP_WRITE) ? RESP_WRITE : RESP_READ;
        end
        if (state == S_SRC) begin
            entry_q.src_id <= data_w;
        end
        if (state == S_ADDR) begin
            addr_sh <= {data_w, addr_sh[31:8]};   // lsb arrives first
        end
        if (state == S_LEN) begin
            entry_q.len <= data_w;
        end
        if (state == S_WDATA) begin
            data_sh <= {data_w, data_sh[31:8]};
        end
        if (state == S_READ && rd_pend) begin
            entry_q.words[cap_idx] <= data_rd;
        end
    end

    assign push  = (state == S_PUSH) && !full;
    assign entry = entry_q;

endmodule

`default_nettype wire

//--- hw/noc_resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module noc_resp_fifo
    import noc_pkg::*;
#(
    parameter int depth = 4
) (
    input  wire logic        c,
    input  wire logic        rst,
    input  wire logic        push,
    input  wire resp_entry_t din,
    input  wire logic        pop,
    output resp_entry_t      dout,
    output logic             full,
    output logic             empty
);

    localparam int AW = (depth > 1) ? $clog2(depth) : 1;
    localparam int NW = $clog2(depth + 1);

    resp_entry_t   mem [depth];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [NW-1:0] count;   // entries held
    logic          wr_en;
    logic          rd_en;

    assign wr_en = push && !full;    // writes into a full queue are dropped
    assign rd_en = pop && !empty;
    assign full  = (count == NW'(depth));
    assign empty = (count == '0);

    always_ff @(posedge c or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(depth - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(depth - 1)) ? '0 : rd_ptr + AW'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + NW'(1);
                2'b01:   count <= count - NW'(1);
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge c) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
        if (rd_en) begin
            dout <= mem[rd_ptr];   // valid the cycle after pop
        end
    end

endmodule

`default_nettype wire

//--- hw/noc_resp_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_resp_serializer
    import noc_pkg::*;
(
    input  wire logic        c,
    input  wire logic        rst,
    input  wire logic        empty,
    input  wire resp_entry_t dout,
    output logic             pop,
    output logic             cmd_r,
    output logic [7:0]       data_r
);

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_e;

    state_e      state;
    logic [7:0]  bidx;       // index of the byte going out next
    logic [7:0]  last_idx;   // index of the final byte of this response
    logic [7:0]  byte_k;     // offset into the read data
    logic [31:0] word_sel;
    logic [7:0]  nxt_byte;
    logic        nxt_cmd;

    // one entry in flight at a time
    assign pop = (state == S_IDLE) && !empty;

    // write: header, id
    // read: header, id, len, data, end code
    assign last_idx = (dout.kind == RESP_WRITE) ? 8'd1 : dout.len + 8'd3;

    always_comb begin
        byte_k   = bidx - 8'd3;
        word_sel = dout.words[byte_k[3:2]];
        nxt_cmd  = 1'b0;
        if (bidx == 8'd0) begin
            nxt_byte = dout.kind;           // header, flagged
            nxt_cmd  = 1'b1;
        end else if (bidx == 8'd1) begin
            nxt_byte = dout.src_id;
        end else if (bidx == 8'd2) begin
            nxt_byte = dout.len;
        end else if (bidx == last_idx) begin
            nxt_byte = `NOC_END_CODE;       // only reached on reads
            nxt_cmd  = 1'b1;
        end else begin
            // word 0 first, lsb first within a word
            nxt_byte = word_sel[byte_k[1:0]*8 +: 8];
        end
    end

    always_ff @(posedge c or posedge rst) begin
        if (rst) begin
            state  <= S_IDLE;
            bidx   <= '0;
            cmd_r  <= 1'b0;
            data_r <= '0;
        end else begin
            cmd_r  <= 1'b0;   // quiet port between responses
            data_r <= '0;
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        bidx  <= '0;
                        state <= S_SEND;   // dout is valid next cycle
                    end
                end
                S_SEND: begin
                    if (bidx > last_idx) begin
                        state <= S_IDLE;   // last byte already on the port
                    end else begin
                        cmd_r  <= nxt_cmd;
                        data_r <= nxt_byte;
                        bidx   <= bidx + 8'd1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/noc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_bridge
    import noc_pkg::*;
(
    input  wire logic        c,
    input  wire logic        rst,
    input  wire logic        cmd_w,
    input  wire logic [7:0]  data_w,
    input  wire logic [31:0] data_rd,
    output logic             cmd_r,
    output logic [7:0]       data_r,
    output logic             sel,
    output logic             rw,
    output logic [31:0]      addr,
    output logic [31:0]      data_wr
);

    // parser to queue
    logic        push;
    resp_entry_t entry;
    logic        full;

    // queue to serializer
    logic        pop;
    resp_entry_t dout;
    logic        empty;

    noc_cmd_parser u_parser (
        .c       (c),
        .rst     (rst),
        .cmd_w   (cmd_w),
        .data_w  (data_w),
        .data_rd (data_rd),
        .full    (full),
        .sel     (sel),
        .rw      (rw),
        .addr    (addr),
        .data_wr (data_wr),
        .push    (push),
        .entry   (entry)
    );

    noc_resp_fifo #(
        .depth (`NOC_FIFO_DEPTH)
    ) u_fifo (
        .c     (c),
        .rst   (rst),
        .push  (push),
        .din   (entry),
        .pop   (pop),
        .dout  (dout),
        .full  (full),
        .empty (empty)
    );

    noc_resp_serializer u_ser (
        .c      (c),
        .rst    (rst),
        .empty  (empty),
        .dout   (dout),
        .pop    (pop),
        .cmd_r  (cmd_r),
        .data_r (data_r)
    );

endmodule

`default_nettype wire

//--- dv/noc_bridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module noc_bridge_sva (
    input wire logic c,
    input wire logic rst,
    input wire logic sel,
    input wire logic rw,
    input wire logic cmd_r
);

    // rw only qualifies a select
    rw_needs_sel: assert property (@(posedge c) disable iff (rst) rw |-> sel)
        else $error("rw high while sel low");

    // first cycle out of reset, bus and response port quiet
    quiet_after_reset: assert property (@(posedge c) $fell(rst) |-> !sel && !cmd_r)
        else $error("sel or cmd_r active right after reset");

    // write strobe is a single cycle pulse
    write_one_cycle: assert property (
        @(posedge c) disable iff (rst) (sel && rw) |=> !(sel && rw)
    ) else $error("write strobe held longer than one cycle");

endmodule

`default_nettype wire

//--- dv/noc_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_bridge_tb;

    localparam int PERIOD = 4;
    localparam int GAP    = 24;   // idle cycles after each command
    localparam int N_CMDS = 26;   // write, 3 reads, write+read, 20 mixed
    localparam int LIMIT  = (N_CMDS * 40 + 100) * PERIOD;

    logic        c;
    logic        rst;
    logic        cmd_w;
    logic [7:0]  data_w;
    logic [31:0] data_rd;
    logic        cmd_r;
    logic [7:0]  data_r;
    logic        sel;
    logic        rw;
    logic [31:0] addr;
    logic [31:0] data_wr;

    logic [31:0] mem [16];    // register model, word index addr[5:2]
    logic [9:0]  exp_q [$];   // {last, cmd_r, data_r} per response byte
    logic [64:0] bus_q [$];   // {rw, addr, data} per bus strobe
    logic [9:0]  exp_byte;
    logic [64:0] exp_bus;
    logic        in_resp;     // inside a response frame
    logic        rd_pend;     // answer on data_rd next cycle
    logic [3:0]  rd_idx;
    logic        wr_prev;     // write strobe seen last cycle

    noc_bridge uut (
        .c       (c),
        .rst     (rst),
        .cmd_w   (cmd_w),
        .data_w  (data_w),
        .data_rd (data_rd),
        .cmd_r   (cmd_r),
        .data_r  (data_r),
        .sel     (sel),
        .rw      (rw),
        .addr    (addr),
        .data_wr (data_wr)
    );

    bind noc_bridge noc_bridge_sva u_sva (
        .c     (c),
        .rst   (rst),
        .sel   (sel),
        .rw    (rw),
        .cmd_r (cmd_r)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else
            stop_with_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else stop_with_failure(what);
    endtask

    initial begin
        c = 1'b0;
        forever #(PERIOD / 2) c = ~c;
    end

    // run length bound, 40 cycles per command plus margin
    initial begin
        #(LIMIT);
        stop_with_failure("timeout: responses did not arrive in time");
    end

    task automatic drive_byte(input logic flag, input logic [7:0] b);
        @(negedge c);
        cmd_w  = flag;
        data_w = b;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge c);
            cmd_w  = 1'b0;
            data_w = 8'h00;
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            drive_byte(1'b0, w[i*8 +: 8]);   // lsb first
        end
    endtask

    // one strobe expected, response is 80 then id
    task automatic do_write(input logic [7:0] id, input logic [31:0] a, input logic [31:0] d);
        bus_q.push_back({1'b1, a, d});
        exp_q.push_back({2'b01, 8'h80});
        exp_q.push_back({2'b10, id});
        drive_byte(1'b1, `NOC_OP_WRITE);
        drive_byte(1'b0, id);
        send_word(a);
        drive_byte(1'b0, 8'($urandom));   // length byte, don't care
        send_word(d);
        idle(GAP);
    endtask

    // len/4 word reads, stride 4, framed by 40 id len ... E0
    task automatic do_read(input logic [7:0] id, input logic [31:0] a, input logic [7:0] len);
        logic [31:0] wa;
        logic [31:0] w;
        exp_q.push_back({2'b01, 8'h40});
        exp_q.push_back({2'b00, id});
        exp_q.push_back({2'b00, len});
        for (int i = 0; i < int'(len) / 4; i++) begin
            wa = a + 32'(i * 4);
            w  = mem[wa[5:2]];
            bus_q.push_back({1'b0, wa, 32'h0});
            for (int k = 0; k < 4; k++) begin
                exp_q.push_back({2'b00, w[k*8 +: 8]});
            end
        end
        exp_q.push_back({2'b11, 8'hE0});
        drive_byte(1'b1, `NOC_OP_READ);
        drive_byte(1'b0, id);
        send_word(a);
        drive_byte(1'b0, len);
        idle(GAP);
    endtask

    // register bus slave, strobes checked against the expected accesses
    always @(negedge c) begin
        data_rd = rd_pend ? mem[rd_idx] : $urandom;   // noise when not answering
        rd_pend = 1'b0;
        if (!rst) begin
            expect_true(!rw || sel, "rw high without sel");
            expect_true(!(wr_prev && sel && rw), "write strobe longer than one cycle");
            wr_prev = sel && rw;
            if (sel) begin
                expect_true(bus_q.size() != 0, "bus strobe with no access expected");
                exp_bus = bus_q.pop_front();
                expect_equal("rw", 32'(rw), 32'(exp_bus[64]));
                expect_equal("addr", addr, exp_bus[63:32]);
                if (rw) begin
                    expect_equal("data_wr", data_wr, exp_bus[31:0]);
                    mem[addr[5:2]] = data_wr;
                end else begin
                    rd_pend = 1'b1;
                    rd_idx  = addr[5:2];
                end
            end
        end
    end

    // response port, byte by byte against exp_q
    always @(negedge c) begin
        if (!rst) begin
            if (in_resp || cmd_r) begin
                expect_true(exp_q.size() != 0, "response byte with nothing expected");
                exp_byte = exp_q.pop_front();
                expect_equal("cmd_r", 32'(cmd_r), 32'(exp_byte[8]));
                expect_equal("data_r", 32'(data_r), 32'(exp_byte[7:0]));
                in_resp = !exp_byte[9];
            end else begin
                expect_equal("data_r", 32'(data_r), 32'h0);   // quiet between frames
            end
        end
    end

    initial begin
        logic [7:0]  id;
        logic [31:0] a;
        logic [31:0] d;
        void'($urandom(75));
        rst     = 1'b1;
        cmd_w   = 1'b0;
        data_w  = 8'h00;
        data_rd = 32'h0;
        in_resp = 1'b0;
        rd_pend = 1'b0;
        rd_idx  = 4'h0;
        wr_prev = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = {4{4'(i), ~4'(i)}};
        end
        repeat (5) @(negedge c);
        rst = 1'b0;
        idle(8);   // nothing may move before the first command
        do_write(8'h11, $urandom, $urandom);
        a = $urandom;
        do_read(8'h21, a, 8'h04);
        do_read(8'h22, a, 8'h08);
        do_read(8'h23, a, 8'h0C);
        a = $urandom;   // read back what was written
        d = $urandom;
        do_write(8'h31, a, d);
        do_read(8'h32, a, 8'h04);
        repeat (20) begin
            id = 8'($urandom);
            a  = $urandom;
            if ($urandom % 2 == 0) begin
                do_write(id, a, $urandom);
            end else begin
                do_read(id, a, 8'(4 * (1 + $urandom % 3)));
            end
        end
        while (exp_q.size() != 0 || in_resp) begin
            @(negedge c);
        end
        idle(4);
        if (bus_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_with_failure("bus accesses still outstanding at the end");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/noc_pkg.sv
hw/noc_cmd_parser.sv
hw/noc_resp_fifo.sv
hw/noc_resp_serializer.sv
hw/noc_bridge.sv
dv/noc_bridge_sva.sv
dv/noc_bridge_tb.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --assert -j 0
TOP   := noc_bridge_tb
FLIST := vlog.f
BUILD := obj_dir
BIN   := $(BUILD)/V$(TOP)
SRCS  := $(shell grep -v '^+' $(FLIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD)
